// File: exec_pkg.sv
// Shared widths, encodings and port structs for a little-endian RV32I integer subset
package exec_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] HALT_INSTR = '1;

    // Major opcodes of the kept subset
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    // Values follow funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_t;

    // Values follow funct3 of branches
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_t;

    typedef enum logic {A_RS1, A_PC} a_sel_t;
    typedef enum logic {B_RS2, B_IMM} b_sel_t;
    typedef enum logic [1:0] {W_ALU, W_LOAD, W_PC4, W_IMM_U} w_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t opcode;
    } s_fmt_t;

    typedef struct packed {
        logic imm_12;
        logic [5:0] imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic imm_11;
        opcode_t opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t opcode;
    } u_fmt_t;

    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t opcode;
    } j_fmt_t;

    // One instruction word seen in each of the six formats
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic valid;
        instr_u instr;
        logic [XLEN-1:0] pc;
        logic prediction;
    } fetch_ex_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_t alu_op;
        a_sel_t a_sel;
        b_sel_t b_sel;
        w_sel_t w_sel;
        logic wen;
        logic dren;
        logic dwen;
        logic branch;
        logic jump;
        logic jalr;
        mem_size_t mem_size;
        branch_t branch_type;
        logic [XLEN-1:0] imm;
        logic illegal;
        logic halt;
    } ctrl_t;

    typedef struct packed {
        logic ren;
        logic wen;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [3:0] byte_en;
    } dmem_req_t;

    typedef struct packed {
        logic en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0] data;
    } wb_t;

endpackage

// File: exec_decoder.sv
// Decoder for the kept RV32I subset; funct7 is only looked at for SUB and SRA/SRAI
`timescale 1ns/1ps

module exec_decoder (
    input  exec_pkg::instr_u instr,
    output exec_pkg::ctrl_t  ctrl
);

    logic [exec_pkg::XLEN-1:0] imm_i;
    logic [exec_pkg::XLEN-1:0] imm_s;
    logic [exec_pkg::XLEN-1:0] imm_b;
    logic [exec_pkg::XLEN-1:0] imm_u;
    logic [exec_pkg::XLEN-1:0] imm_j;
    logic [2:0] funct3;

    // Same funct3 map for OP and OP_IMM, alt picks SUB or SRA
    function automatic exec_pkg::alu_op_t alu_for(input logic [2:0] f3, input logic alt);
        exec_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = alt ? exec_pkg::ALU_SUB : exec_pkg::ALU_ADD;
            3'b001:  op = exec_pkg::ALU_SLL;
            3'b010:  op = exec_pkg::ALU_SLT;
            3'b011:  op = exec_pkg::ALU_SLTU;
            3'b100:  op = exec_pkg::ALU_XOR;
            3'b101:  op = alt ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
            3'b110:  op = exec_pkg::ALU_OR;
            default: op = exec_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign funct3 = instr.r_fmt.funct3;

    // Immediates of every format, sign-extended
    assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm, 12'b0};
    assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                    instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        ctrl = '0;
        ctrl.rs1 = instr.r_fmt.rs1;
        ctrl.rs2 = instr.r_fmt.rs2;
        ctrl.rd = instr.r_fmt.rd;
        ctrl.mem_size = exec_pkg::mem_size_t'(funct3);
        ctrl.branch_type = exec_pkg::branch_t'(funct3);

        if (instr == exec_pkg::HALT_INSTR) begin
            ctrl.halt = 1'b1;
        end else begin
            case (instr.r_fmt.opcode)
                exec_pkg::LUI: begin
                    ctrl.imm = imm_u;
                    ctrl.w_sel = exec_pkg::W_IMM_U;
                    ctrl.wen = 1'b1;
                end
                exec_pkg::AUIPC: begin
                    ctrl.imm = imm_u;
                    ctrl.a_sel = exec_pkg::A_PC;
                    ctrl.b_sel = exec_pkg::B_IMM;
                    ctrl.wen = 1'b1;
                end
                exec_pkg::JAL: begin
                    ctrl.imm = imm_j;
                    ctrl.w_sel = exec_pkg::W_PC4;
                    ctrl.jump = 1'b1;
                    ctrl.wen = 1'b1;
                end
                exec_pkg::JALR: begin
                    ctrl.imm = imm_i;
                    ctrl.w_sel = exec_pkg::W_PC4;
                    ctrl.illegal = (funct3 != 3'b000);
                    ctrl.jump = !ctrl.illegal;
                    ctrl.jalr = !ctrl.illegal;
                    ctrl.wen = 1'b1;
                end
                exec_pkg::BRANCH: begin
                    ctrl.imm = imm_b;
                    ctrl.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
                    ctrl.branch = !ctrl.illegal;
                end
                exec_pkg::LOAD: begin
                    ctrl.imm = imm_i;
                    ctrl.b_sel = exec_pkg::B_IMM;
                    ctrl.w_sel = exec_pkg::W_LOAD;
                    ctrl.illegal = !(funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
                    ctrl.dren = 1'b1;
                    ctrl.wen = 1'b1;
                end
                exec_pkg::STORE: begin
                    ctrl.imm = imm_s;
                    ctrl.b_sel = exec_pkg::B_IMM;
                    ctrl.illegal = !(funct3 inside {3'b000, 3'b001, 3'b010});
                    ctrl.dwen = 1'b1;
                end
                exec_pkg::OP_IMM: begin
                    ctrl.imm = imm_i;
                    ctrl.b_sel = exec_pkg::B_IMM;
                    // ADDI never turns into SUB
                    ctrl.alu_op = alu_for(funct3, instr.r_fmt.funct7[5] && (funct3 != 3'b000));
                    ctrl.wen = 1'b1;
                end
                exec_pkg::OP: begin
                    ctrl.alu_op = alu_for(funct3, instr.r_fmt.funct7[5]);
                    ctrl.wen = 1'b1;
                end
                default: begin
                    ctrl.illegal = 1'b1;
                end
            endcase
        end

        // An illegal word must not write or touch memory
        if (ctrl.illegal) begin
            ctrl.wen = 1'b0;
            ctrl.dren = 1'b0;
            ctrl.dwen = 1'b0;
        end
    end

endmodule

// File: exec_reg_file.sv
// 32 x 32 register file, reads are combinational and the write lands on the next edge
`timescale 1ns/1ps

module exec_reg_file (
    input  logic CLK,
    input  logic nRST,
    input  logic [exec_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [exec_pkg::REG_ADDR_W-1:0] rs2,
    output logic [exec_pkg::XLEN-1:0] rs1_data,
    output logic [exec_pkg::XLEN-1:0] rs2_data,
    input  exec_pkg::wb_t wb
);

    logic [exec_pkg::XLEN-1:0] regs [2**exec_pkg::REG_ADDR_W];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 2**exec_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 stays zero whatever the writeback port carries
    a_x0_zero: assert property (@(posedge CLK) disable iff (!nRST) regs[0] == '0);

endmodule

// File: exec_alu.sv
// RV32I integer ALU, shift amount is the low five bits of b
`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::alu_op_t op,
    input  logic [exec_pkg::XLEN-1:0] a,
    input  logic [exec_pkg::XLEN-1:0] b,
    output logic [exec_pkg::XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            exec_pkg::ALU_ADD:  result = a + b;
            exec_pkg::ALU_SUB:  result = a - b;
            exec_pkg::ALU_SLL:  result = a << shamt;
            exec_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::ALU_SLTU: result = {31'b0, a < b};
            exec_pkg::ALU_XOR:  result = a ^ b;
            exec_pkg::ALU_SRL:  result = a >> shamt;
            exec_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            exec_pkg::ALU_OR:   result = a | b;
            exec_pkg::ALU_AND:  result = a & b;
            default:            result = '0;
        endcase
    end

endmodule

// File: branch_jump_unit.sv
// Branch and jump resolution, mispredict is not qualified by valid here
`timescale 1ns/1ps

module branch_jump_unit (
    input  exec_pkg::ctrl_t ctrl,
    input  logic [exec_pkg::XLEN-1:0] pc,
    input  logic [exec_pkg::XLEN-1:0] rs1_data,
    input  logic [exec_pkg::XLEN-1:0] rs2_data,
    input  logic prediction,
    output logic [exec_pkg::XLEN-1:0] redirect_addr,
    output logic taken,
    output logic mispredict
);

    logic cond;
    logic [exec_pkg::XLEN-1:0] pc_target;
    logic [exec_pkg::XLEN-1:0] jalr_target;

    always_comb begin
        case (ctrl.branch_type)
            exec_pkg::BEQ:  cond = (rs1_data == rs2_data);
            exec_pkg::BNE:  cond = (rs1_data != rs2_data);
            exec_pkg::BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
            exec_pkg::BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            exec_pkg::BLTU: cond = (rs1_data < rs2_data);
            exec_pkg::BGEU: cond = (rs1_data >= rs2_data);
            default:        cond = 1'b0;
        endcase
    end

    assign taken = ctrl.branch && cond;

    assign pc_target = pc + ctrl.imm;
    // JALR target has bit 0 cleared
    assign jalr_target = (rs1_data + ctrl.imm) & ~32'd1;

    always_comb begin
        if (ctrl.jalr) begin
            redirect_addr = jalr_target;
        end else if (ctrl.jump || taken) begin
            redirect_addr = pc_target;
        end else begin
            redirect_addr = pc + 32'd4;
        end
    end

    assign mispredict = prediction ^ taken;

endmodule

// File: load_store_unit.sv
// Little-endian data-bus port, memory must answer in the same cycle
`timescale 1ns/1ps

module load_store_unit (
    input  exec_pkg::ctrl_t ctrl,
    input  logic valid,
    input  logic [exec_pkg::XLEN-1:0] addr,
    input  logic [exec_pkg::XLEN-1:0] rs2_data,
    input  logic [exec_pkg::XLEN-1:0] dmem_rdata,
    output exec_pkg::dmem_req_t dmem_req,
    output logic [exec_pkg::XLEN-1:0] load_data,
    output logic misaligned
);

    logic mis_addr;
    logic [exec_pkg::XLEN-1:0] lane;

    always_comb begin
        case (ctrl.mem_size)
            exec_pkg::MEM_W:                  mis_addr = (addr[1:0] != 2'b00);
            exec_pkg::MEM_H, exec_pkg::MEM_HU: mis_addr = addr[0];
            default:                          mis_addr = 1'b0;
        endcase
    end

    assign misaligned = valid && (ctrl.dren || ctrl.dwen) && mis_addr;

    always_comb begin
        dmem_req.ren = valid && ctrl.dren && !mis_addr;
        dmem_req.wen = valid && ctrl.dwen && !mis_addr;
        dmem_req.addr = addr;
        case (ctrl.mem_size)
            exec_pkg::MEM_B, exec_pkg::MEM_BU: begin
                dmem_req.byte_en = 4'b0001 << addr[1:0];
                dmem_req.wdata = {4{rs2_data[7:0]}};
            end
            exec_pkg::MEM_H, exec_pkg::MEM_HU: begin
                dmem_req.byte_en = addr[1] ? 4'b1100 : 4'b0011;
                dmem_req.wdata = {2{rs2_data[15:0]}};
            end
            default: begin
                dmem_req.byte_en = 4'b1111;
                dmem_req.wdata = rs2_data;
            end
        endcase
    end

    // Bring the addressed lane down to bit 0
    assign lane = dmem_rdata >> {addr[1:0], 3'b000};

    always_comb begin
        case (ctrl.mem_size)
            exec_pkg::MEM_B:  load_data = {{24{lane[7]}}, lane[7:0]};
            exec_pkg::MEM_BU: load_data = {24'b0, lane[7:0]};
            exec_pkg::MEM_H:  load_data = {{16{lane[15]}}, lane[15:0]};
            exec_pkg::MEM_HU: load_data = {16'b0, lane[15:0]};
            default:          load_data = dmem_rdata;
        endcase
    end

    // The decoder never raises both a load and a store
    always_comb begin
        a_no_rw: assert final (!(dmem_req.ren && dmem_req.wen));
    end

endmodule

// File: execute_stage.sv
// Execute stage top level taking one instruction per valid strobe with no back-pressure
`timescale 1ns/1ps

module execute_stage (
    input  logic CLK,
    input  logic nRST,
    input  exec_pkg::fetch_ex_t fetch_ex,
    input  logic [exec_pkg::XLEN-1:0] dmem_rdata,
    output exec_pkg::dmem_req_t dmem_req,
    output exec_pkg::wb_t wb,
    output logic [exec_pkg::XLEN-1:0] redirect_addr,
    output logic mispredict,
    output logic misaligned,
    output logic illegal,
    output logic halt
);

    exec_pkg::ctrl_t ctrl;
    logic [exec_pkg::XLEN-1:0] rs1_data;
    logic [exec_pkg::XLEN-1:0] rs2_data;
    logic [exec_pkg::XLEN-1:0] alu_a;
    logic [exec_pkg::XLEN-1:0] alu_b;
    logic [exec_pkg::XLEN-1:0] alu_result;
    logic [exec_pkg::XLEN-1:0] load_data;
    logic [exec_pkg::XLEN-1:0] pc4;
    logic bj_mispredict;
    logic lsu_valid;

    exec_decoder i_decoder (
        .instr(fetch_ex.instr),
        .ctrl (ctrl)
    );

    exec_reg_file i_reg_file (
        .CLK     (CLK),
        .nRST    (nRST),
        .rs1     (ctrl.rs1),
        .rs2     (ctrl.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb      (wb)
    );

    assign alu_a = (ctrl.a_sel == exec_pkg::A_PC) ? fetch_ex.pc : rs1_data;
    assign alu_b = (ctrl.b_sel == exec_pkg::B_IMM) ? ctrl.imm : rs2_data;

    exec_alu i_alu (
        .op    (ctrl.alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .result(alu_result)
    );

    branch_jump_unit i_bju (
        .ctrl         (ctrl),
        .pc           (fetch_ex.pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .prediction   (fetch_ex.prediction),
        .redirect_addr(redirect_addr),
        .taken        (),
        .mispredict   (bj_mispredict)
    );

    // Once halted, memory is left alone
    assign lsu_valid = fetch_ex.valid && !halt;

    load_store_unit i_lsu (
        .ctrl      (ctrl),
        .valid     (lsu_valid),
        .addr      (alu_result),
        .rs2_data  (rs2_data),
        .dmem_rdata(dmem_rdata),
        .dmem_req  (dmem_req),
        .load_data (load_data),
        .misaligned(misaligned)
    );

    assign pc4 = fetch_ex.pc + 32'd4;

    always_comb begin
        case (ctrl.w_sel)
            exec_pkg::W_LOAD:  wb.data = load_data;
            exec_pkg::W_PC4:   wb.data = pc4;
            exec_pkg::W_IMM_U: wb.data = ctrl.imm;
            default:           wb.data = alu_result;
        endcase
    end

    assign wb.rd = ctrl.rd;
    // A misaligned load brings back nothing to write
    assign wb.en = fetch_ex.valid && ctrl.wen && !halt && !(ctrl.dren && misaligned);

    assign mispredict = fetch_ex.valid && bj_mispredict;
    assign illegal = fetch_ex.valid && ctrl.illegal;

    // Sticky until reset
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            halt <= 1'b0;
        end else if (fetch_ex.valid && ctrl.halt) begin
            halt <= 1'b1;
        end
    end

    // After halt nothing reaches the register file or the data bus
    a_halt_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        halt |-> !(wb.en || dmem_req.ren || dmem_req.wen));

endmodule

// File: tb_exec_model.svh
// Reference model of registers, data memory and outputs; memory wraps at 256 words on addr[9:2]
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

logic [31:0] model_regs [32];
logic [31:0] model_mem [256];
logic model_halted;

// Expected outputs of the strobe being checked
exec_pkg::wb_t exp_wb;
exec_pkg::dmem_req_t exp_req;
logic [1:0] exp_mem_op;
logic [31:0] exp_redirect;
logic exp_mispredict;
logic exp_misaligned;
logic exp_illegal;

// Fill pattern that depends on every bit of the word index
function automatic logic [31:0] fill_word(input int idx);
    return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5a, idx[7:0] + 8'h33};
endfunction

function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                            input logic [3:0] be);
    logic [31:0] w;
    w = old;
    for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
            w[8*i +: 8] = data[8*i +: 8];
        end
    end
    return w;
endfunction

// RV32I arithmetic by funct3, alt selects SUB or SRA
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
    case (f3)
        3'b000: return alt ? x - y : x + y;
        3'b001: return x << y[4:0];
        3'b010: return {31'b0, $signed(x) < $signed(y)};
        3'b011: return {31'b0, x < y};
        3'b100: return x ^ y;
        3'b101: begin
            if (alt) begin
                return $signed(x) >>> y[4:0];
            end
            return x >> y[4:0];
        end
        3'b110: return x | y;
        default: return x & y;
    endcase
endfunction

task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        model_mem[i] = fill_word(i);
    end
    model_halted = 1'b0;
endtask

task automatic predict_strobe(input logic valid, input logic [31:0] instr,
                              input logic [31:0] pc, input logic pred);
    logic [2:0] f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] lane;
    logic [31:0] res;
    logic legal;
    logic wr;
    logic take;
    logic mis;
    f3 = instr[14:12];
    a = model_regs[instr[19:15]];
    b = model_regs[instr[24:20]];
    addr = '0;
    res = '0;
    legal = 1'b1;
    wr = 1'b0;
    take = 1'b0;
    exp_req = '0;
    exp_mem_op = 2'b00;
    exp_redirect = pc + 32'd4;
    // The all-ones word is the halt and does nothing else
    if (instr != 32'hffff_ffff) begin
        case (instr[6:0])
            7'b0110111: begin
                res = {instr[31:12], 12'b0};
                wr = 1'b1;
            end
            7'b0010111: begin
                res = pc + {instr[31:12], 12'b0};
                wr = 1'b1;
            end
            7'b1101111: begin
                res = pc + 32'd4;
                wr = 1'b1;
                exp_redirect = pc + {{12{instr[31]}}, instr[19:12], instr[20],
                                     instr[30:21], 1'b0};
            end
            7'b1100111: begin
                legal = (f3 == 3'b000);
                res = pc + 32'd4;
                wr = 1'b1;
                if (legal) begin
                    exp_redirect = (a + sext12(instr[31:20])) & ~32'd1;
                end
            end
            7'b1100011: begin
                case (f3)
                    3'b000: take = (a == b);
                    3'b001: take = (a != b);
                    3'b100: take = ($signed(a) < $signed(b));
                    3'b101: take = ($signed(a) >= $signed(b));
                    3'b110: take = (a < b);
                    3'b111: take = (a >= b);
                    default: legal = 1'b0;
                endcase
                if (take) begin
                    exp_redirect = pc + {{20{instr[31]}}, instr[7], instr[30:25],
                                         instr[11:8], 1'b0};
                end
            end
            7'b0000011: begin
                legal = (f3 != 3'b011) && (f3[2:1] != 2'b11);
                addr = a + sext12(instr[31:20]);
                exp_mem_op = 2'b01;
                wr = 1'b1;
                lane = model_mem[addr[9:2]] >> {addr[1:0], 3'b000};
                case (f3)
                    3'b000: res = {{24{lane[7]}}, lane[7:0]};
                    3'b001: res = {{16{lane[15]}}, lane[15:0]};
                    3'b100: res = {24'b0, lane[7:0]};
                    3'b101: res = {16'b0, lane[15:0]};
                    default: res = model_mem[addr[9:2]];
                endcase
            end
            7'b0100011: begin
                legal = !f3[2] && (f3[1:0] != 2'b11);
                addr = a + sext12({instr[31:25], instr[11:7]});
                exp_mem_op = 2'b10;
            end
            7'b0010011: begin
                res = alu_ref(f3, instr[30] && (f3 == 3'b101), a, sext12(instr[31:20]));
                wr = 1'b1;
            end
            7'b0110011: begin
                res = alu_ref(f3, instr[30], a, b);
                wr = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // Memory is only touched by a legal access before halt
    if (!valid || model_halted || !legal) begin
        exp_mem_op = 2'b00;
    end
    case (f3[1:0])
        2'b10: mis = (addr[1:0] != 2'b00);
        2'b01: mis = addr[0];
        default: mis = 1'b0;
    endcase
    case (f3[1:0])
        2'b00: begin
            exp_req.byte_en = 4'b0001 << addr[1:0];
            exp_req.wdata = {4{b[7:0]}};
        end
        2'b01: begin
            exp_req.byte_en = addr[1] ? 4'b1100 : 4'b0011;
            exp_req.wdata = {2{b[15:0]}};
        end
        default: begin
            exp_req.byte_en = 4'b1111;
            exp_req.wdata = b;
        end
    endcase
    exp_req.addr = addr;
    exp_req.ren = exp_mem_op[0] && !mis;
    exp_req.wen = exp_mem_op[1] && !mis;
    exp_misaligned = (exp_mem_op != 2'b00) && mis;
    exp_wb.en = valid && !model_halted && legal && wr && !(exp_mem_op[0] && mis);
    exp_wb.rd = instr[11:7];
    exp_wb.data = res;
    exp_illegal = valid && !legal;
    exp_mispredict = valid && (pred ^ take);
endtask

task automatic commit_strobe(input logic valid, input logic [31:0] instr);
    if (exp_wb.en && (exp_wb.rd != 5'd0)) begin
        model_regs[exp_wb.rd] = exp_wb.data;
    end
    if (exp_req.wen) begin
        model_mem[exp_req.addr[9:2]] = merge_bytes(model_mem[exp_req.addr[9:2]],
                                                   exp_req.wdata, exp_req.byte_en);
    end
    if (valid && (instr == 32'hffff_ffff)) begin
        model_halted = 1'b1;
    end
endtask

`endif

// File: tb_execute_stage.sv
// Random self-checking testbench with a fixed seed; one halt is sent 21 strobes before the end
`timescale 1ns/1ps

module tb_execute_stage;

    localparam int NUM_STROBES = 2000;
    localparam int HALT_AT = NUM_STROBES - 21;
    localparam int RESET_CYCLES = 2;
    localparam int CLK_PERIOD = 20;

    logic CLK;
    logic nRST;
    exec_pkg::fetch_ex_t fetch_ex;
    logic [31:0] dmem_rdata;
    exec_pkg::dmem_req_t dmem_req;
    exec_pkg::wb_t wb;
    logic [31:0] redirect_addr;
    logic mispredict;
    logic misaligned;
    logic illegal;
    logic halt;

    logic [31:0] bus_mem [256];
    integer seed;
    int errors;
    int strobes;

    `include "tb_exec_model.svh"

    execute_stage i_dut (
        .CLK          (CLK),
        .nRST         (nRST),
        .fetch_ex     (fetch_ex),
        .dmem_rdata   (dmem_rdata),
        .dmem_req     (dmem_req),
        .wb           (wb),
        .redirect_addr(redirect_addr),
        .mispredict   (mispredict),
        .misaligned   (misaligned),
        .illegal      (illegal),
        .halt         (halt)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Data memory answers in the same cycle and takes stores at the edge
    assign dmem_rdata = bus_mem[dmem_req.addr[9:2]];

    always @(posedge CLK) begin
        if (dmem_req.wen) begin
            bus_mem[dmem_req.addr[9:2]] <= merge_bytes(bus_mem[dmem_req.addr[9:2]],
                                                       dmem_req.wdata, dmem_req.byte_en);
        end
    end

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    // Random instruction of the kept subset, about one in twenty is illegal
    function automatic logic [31:0] make_instr();
        logic [31:0] fld;
        logic [31:0] imm;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        int kind;
        fld = $random(seed);
        imm = $random(seed);
        rd = {2'b00, fld[2:0]};
        rs1 = {2'b00, fld[5:3]};
        rs2 = {2'b00, fld[8:6]};
        f3 = fld[11:9];
        kind = int'(fld[31:16] % 16'd20);
        case (kind)
            0: return {imm[31:7], 7'b0001011};
            1: return {imm[31:12], rd, 7'b0110111};
            2: return {imm[31:12], rd, 7'b0010111};
            3: return {imm[31:12], rd, 7'b1101111};
            4: return {imm[31:20], rs1, 3'b000, rd, 7'b1100111};
            5, 6: begin
                // funct3 010 and 011 are no branch
                if (f3[2:1] == 2'b01) begin
                    f3 = f3 ^ 3'b100;
                end
                return {imm[31:25], rs2, rs1, f3, imm[11:7], 7'b1100011};
            end
            7, 8, 9: begin
                if ((f3 == 3'b011) || (f3[2:1] == 2'b11)) begin
                    f3 = f3 & 3'b101;
                end
                return {imm[31:20], rs1, f3, rd, 7'b0000011};
            end
            10, 11: begin
                f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
                return {imm[31:25], rs2, rs1, f3, imm[11:7], 7'b0100011};
            end
            12, 13, 14, 15: begin
                if (f3 == 3'b001) begin
                    imm[31:25] = 7'b0;
                end
                if (f3 == 3'b101) begin
                    imm[31:25] = {1'b0, imm[30], 5'b0};
                end
                return {imm[31:20], rs1, f3, rd, 7'b0010011};
            end
            default: begin
                imm[31:25] = {1'b0, imm[30] && ((f3 == 3'b000) || (f3 == 3'b101)), 5'b0};
                return {imm[31:25], rs2, rs1, f3, rd, 7'b0110011};
            end
        endcase
    endfunction

    task automatic check_outputs();
        if (wb.en !== exp_wb.en) begin
            mismatch("wb.en", 32'(wb.en), 32'(exp_wb.en));
        end
        if (exp_wb.en && (wb.rd !== exp_wb.rd)) begin
            mismatch("wb.rd", 32'(wb.rd), 32'(exp_wb.rd));
        end
        if (exp_wb.en && (wb.data !== exp_wb.data)) begin
            mismatch("wb.data", wb.data, exp_wb.data);
        end
        if (dmem_req.ren !== exp_req.ren) begin
            mismatch("dmem_req.ren", 32'(dmem_req.ren), 32'(exp_req.ren));
        end
        if (dmem_req.wen !== exp_req.wen) begin
            mismatch("dmem_req.wen", 32'(dmem_req.wen), 32'(exp_req.wen));
        end
        if ((exp_mem_op != 2'b00) && (dmem_req.addr !== exp_req.addr)) begin
            mismatch("dmem_req.addr", dmem_req.addr, exp_req.addr);
        end
        if ((exp_mem_op != 2'b00) && (dmem_req.byte_en !== exp_req.byte_en)) begin
            mismatch("dmem_req.byte_en", 32'(dmem_req.byte_en), 32'(exp_req.byte_en));
        end
        if (exp_mem_op[1] && (dmem_req.wdata !== exp_req.wdata)) begin
            mismatch("dmem_req.wdata", dmem_req.wdata, exp_req.wdata);
        end
        if (redirect_addr !== exp_redirect) begin
            mismatch("redirect_addr", redirect_addr, exp_redirect);
        end
        if (mispredict !== exp_mispredict) begin
            mismatch("mispredict", 32'(mispredict), 32'(exp_mispredict));
        end
        if (misaligned !== exp_misaligned) begin
            mismatch("misaligned", 32'(misaligned), 32'(exp_misaligned));
        end
        if (illegal !== exp_illegal) begin
            mismatch("illegal", 32'(illegal), 32'(exp_illegal));
        end
        if (halt !== model_halted) begin
            mismatch("halt", 32'(halt), 32'(model_halted));
        end
    endtask

    initial begin
        exec_pkg::fetch_ex_t f;
        logic [31:0] rnd;
        logic [31:0] ins;
        logic v;
        seed = 32'h89aad12b;
        errors = 0;
        strobes = 0;
        nRST = 1'b0;
        fetch_ex = '0;
        reset_model();
        for (int i = 0; i < 256; i++) begin
            bus_mem[i] = fill_word(i);
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        // Idle cycle straight after reset
        @(negedge CLK);
        predict_strobe(1'b0, '0, '0, 1'b0);
        check_outputs();

        for (int n = 0; n < NUM_STROBES; n++) begin
            rnd = $random(seed);
            v = (n == HALT_AT) || (rnd[1:0] != 2'b00);
            ins = (n == HALT_AT) ? exec_pkg::HALT_INSTR : make_instr();
            f.valid = v;
            f.instr = ins;
            f.prediction = rnd[2];
            rnd = $random(seed);
            f.pc = {rnd[31:2], 2'b00};
            @(posedge CLK);
            fetch_ex <= f;
            @(negedge CLK);
            predict_strobe(v, ins, f.pc, f.prediction);
            check_outputs();
            commit_strobe(v, ins);
            if (v) begin
                strobes++;
            end
        end

        // Let the last store land before the memories are compared
        @(posedge CLK);
        fetch_ex <= '0;
        @(negedge CLK);
        for (int i = 0; i < 256; i++) begin
            if (bus_mem[i] !== model_mem[i]) begin
                mismatch($sformatf("bus_mem[%0d]", i), bus_mem[i], model_mem[i]);
            end
        end

        $display("Valid strobes: %0d, errors: %0d", strobes, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #((NUM_STROBES + RESET_CYCLES + 100) * CLK_PERIOD);
        $display("Watchdog expired before all strobes were checked");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
exec_pkg.sv
exec_decoder.sv
exec_reg_file.sv
exec_alu.sv
branch_jump_unit.sv
load_store_unit.sv
execute_stage.sv
tb_execute_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_execute_stage -o sim_exec \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_exec 2>&1 | tee sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
